/* list.f */
+incdir+.
thr_state_pkg.sv
ll_unit_pkg.sv
thr_wait_mask.sv
thr_sched_fsm.sv
thr_issue_pipe.sv
thr_state_check.sv
thr_ctl_top.sv
thr_ctl_properties.sv
tb_thr_ctl.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_thr_ctl
FILELIST  := list.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* tb_thr_ctl.sv */
// Testbench for the thread control block
//   Clock and 16-cycle reset
//   Table of strobes with expected masks, states, issue and error flags
//   Seeded random store-buffer rounds on single threads
//   One compare task, timeout-guarded waits and pass/fail reporting

`timescale 1ns/1ps
`default_nettype none
`include "thr_ctl_cfg.svh"

module tb_thr_ctl;

   localparam logic [2:0] wt   = thr_state_pkg::THR_WAIT;
   localparam logic [2:0] rdy  = thr_state_pkg::THR_RDY;
   localparam logic [2:0] srdy = thr_state_pkg::THR_SPEC_RDY;
   localparam logic [2:0] run  = thr_state_pkg::THR_RUN;
   localparam logic [2:0] srun = thr_state_pkg::THR_SPEC_RUN;
   localparam logic [1:0] u_mul = ll_unit_pkg::LL_MUL;
   localparam logic [1:0] u_div = ll_unit_pkg::LL_DIV;
   localparam logic [1:0] u_fp  = ll_unit_pkg::LL_FP;
   localparam int issue_limit = 10;

   // One table row holds the strobes of one cycle and the outputs after the next edge
   typedef struct packed {
      logic              rst;
      logic [`THR_N-1:0] ims;
      logic [`THR_N-1:0] imc;
      logic [`THR_N-1:0] sts;
      logic [`THR_N-1:0] stc;
      logic [`THR_N-1:0] fl;
      logic              lli;
      logic [1:0]        llu;
      logic [`TID_W-1:0] llt;
      logic [2:0]        lld;
      logic              ue;
      logic [`THR_N-1:0] e_im;
      logic [`THR_N-1:0] e_ot;
      logic [`THR_N-1:0] e_st;
      logic [3*`THR_N-1:0] e_state;
      logic              e_iv;
      logic [`TID_W-1:0] e_tid;
      logic [`THR_N-1:0] e_ew;
      logic [`THR_N-1:0] e_er;
      logic [`THR_N-1:0] e_es;
   } row_t;

   logic                                   clk;
   logic                                   rst_l;
   logic [`THR_N-1:0]                      imiss_set;
   logic [`THR_N-1:0]                      imiss_clr;
   logic [`THR_N-1:0]                      stb_set;
   logic [`THR_N-1:0]                      stb_clr;
   logic [`THR_N-1:0]                      flush;
   logic                                   ll_issue;
   ll_unit_pkg::ll_unit_e                  ll_unit;
   logic [`TID_W-1:0]                      ll_tid;
   logic [ll_unit_pkg::LL_UNIT_N-1:0]      ll_done;
   logic                                   fetch_ue;
   logic [`THR_N-1:0]                      wm_imiss;
   logic [`THR_N-1:0]                      wm_other;
   logic [`THR_N-1:0]                      wm_stbwait;
   thr_state_pkg::thr_state_e [`THR_N-1:0] thr_state;
   logic                                   issue_valid;
   logic [`TID_W-1:0]                      issue_tid;
   logic [`THR_N-1:0]                      chk_err_wait;
   logic [`THR_N-1:0]                      chk_err_run;
   logic [`THR_N-1:0]                      chk_err_sync;

   row_t   rows[$];
   int     row_idx;
   integer seed;

   thr_ctl_top dut (
      .clk          (clk),
      .rst_l        (rst_l),
      .imiss_set    (imiss_set),
      .imiss_clr    (imiss_clr),
      .stb_set      (stb_set),
      .stb_clr      (stb_clr),
      .flush        (flush),
      .ll_issue     (ll_issue),
      .ll_unit      (ll_unit),
      .ll_tid       (ll_tid),
      .ll_done      (ll_done),
      .fetch_ue     (fetch_ue),
      .wm_imiss     (wm_imiss),
      .wm_other     (wm_other),
      .wm_stbwait   (wm_stbwait),
      .thr_state    (thr_state),
      .issue_valid  (issue_valid),
      .issue_tid    (issue_tid),
      .chk_err_wait (chk_err_wait),
      .chk_err_run  (chk_err_run),
      .chk_err_sync (chk_err_sync)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic stop_on_failure(input string msg);
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
         stop_on_failure($sformatf("Error: step %0d %s = 0x%0h, expected 0x%0h",
                                   row_idx, name, got, exp));
   endtask

   // Thread 0 goes in the low bits, as in the packed state array
   function automatic logic [3*`THR_N-1:0] pack_states(input logic [2:0] s0,
      input logic [2:0] s1, input logic [2:0] s2, input logic [2:0] s3);
      return {s3, s2, s1, s0};
   endfunction

   task automatic add_row(input logic rst, input logic [3:0] ims, input logic [3:0] imc,
      input logic [3:0] sts, input logic [3:0] stc, input logic [3:0] fl,
      input logic lli, input logic [1:0] llu, input logic [1:0] llt, input logic [2:0] lld,
      input logic ue, input logic [3:0] e_im, input logic [3:0] e_ot,
      input logic [3:0] e_st, input logic [11:0] e_state, input logic e_iv,
      input logic [1:0] e_tid, input logic [3:0] e_ew, input logic [3:0] e_er,
      input logic [3:0] e_es);
      row_t r;
      r = {rst, ims, imc, sts, stc, fl, lli, llu, llt, lld, ue,
           e_im, e_ot, e_st, e_state, e_iv, e_tid, e_ew, e_er, e_es};
      rows.push_back(r);
   endtask

   task automatic build_table;
      // Reset values
      add_row(1'b1, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, rdy, rdy, rdy), 1'b0, 2'd3, 4'h0, 4'h0, 4'h0);
      // Round robin over four ready threads
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(run, rdy, rdy, rdy), 1'b1, 2'd0, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, run, rdy, rdy), 1'b1, 2'd1, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, rdy, run, rdy), 1'b1, 2'd2, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, rdy, rdy, run), 1'b1, 2'd3, 4'h0, 4'h0, 4'h0);
      // Imiss and store-buffer masks on thread 0 where set beats clear in row 8
      add_row(1'b0, 4'h1, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h1, 4'h0, 4'h0, pack_states(wt, run, rdy, rdy), 1'b1, 2'd1, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h1, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h1, 4'h0, 4'h1, pack_states(wt, rdy, run, rdy), 1'b1, 2'd2, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h1, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h1, pack_states(wt, rdy, rdy, run), 1'b1, 2'd3, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h1, 4'h1, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h1, pack_states(wt, run, rdy, rdy), 1'b1, 2'd1, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h1, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, rdy, run, rdy), 1'b1, 2'd2, 4'h0, 4'h0, 4'h0);
      // Multiply for thread 1 and a dropped second issue to the busy unit
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b1, u_mul, 2'd1, 3'h0, 1'b0,
              4'h0, 4'h2, 4'h0, pack_states(rdy, wt, rdy, run), 1'b1, 2'd3, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b1, u_mul, 2'd2, 3'h0, 1'b0,
              4'h0, 4'h2, 4'h0, pack_states(run, wt, rdy, rdy), 1'b1, 2'd0, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h1, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, srdy, run, rdy), 1'b1, 2'd2, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, rdy, rdy, run), 1'b1, 2'd3, 4'h0, 4'h0, 4'h0);
      // Divide for thread 0 completes when the pointer favours it, giving SPEC_RUN
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b1, u_div, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h1, 4'h0, pack_states(wt, run, rdy, rdy), 1'b1, 2'd1, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h1, 4'h0, pack_states(wt, rdy, run, rdy), 1'b1, 2'd2, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h2, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(srdy, rdy, rdy, run), 1'b1, 2'd3, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(srun, rdy, rdy, rdy), 1'b1, 2'd0, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, run, rdy, rdy), 1'b1, 2'd1, 4'h0, 4'h0, 4'h0);
      // All threads wait and nothing issues
      add_row(1'b0, 4'hf, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'hf, 4'h0, 4'h0, pack_states(wt, wt, wt, wt), 1'b0, 2'd1, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'hf, 4'h0, 4'h0, pack_states(wt, wt, wt, wt), 1'b0, 2'd1, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'hf, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, rdy, rdy, rdy), 1'b0, 2'd1, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, rdy, run, rdy), 1'b1, 2'd2, 4'h0, 4'h0, 4'h0);
      // Flush of thread 3 while it owns the FP unit
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b1, u_fp, 2'd3, 3'h0, 1'b0,
              4'h0, 4'h8, 4'h0, pack_states(run, rdy, rdy, wt), 1'b1, 2'd0, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h8, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, run, rdy, rdy), 1'b1, 2'd1, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, rdy, run, rdy), 1'b1, 2'd2, 4'h0, 4'h0, 4'h8);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h4, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, rdy, rdy, run), 1'b1, 2'd3, 4'h0, 4'h0, 4'h8);
      add_row(1'b1, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, rdy, rdy, rdy), 1'b0, 2'd3, 4'h0, 4'h0, 4'h0);
      // Same flush with a fetch error of thread 3 in the pipe.
      // The unit stays busy until the error has reached W
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(run, rdy, rdy, rdy), 1'b1, 2'd0, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, run, rdy, rdy), 1'b1, 2'd1, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, rdy, run, rdy), 1'b1, 2'd2, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, rdy, rdy, run), 1'b1, 2'd3, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b1, u_fp, 2'd3, 3'h0, 1'b1,
              4'h0, 4'h8, 4'h0, pack_states(run, rdy, rdy, wt), 1'b1, 2'd0, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h8, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, run, rdy, rdy), 1'b1, 2'd1, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, rdy, run, rdy), 1'b1, 2'd2, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h4, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(rdy, rdy, rdy, run), 1'b1, 2'd3, 4'h0, 4'h0, 4'h0);
      add_row(1'b0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, u_mul, 2'd0, 3'h0, 1'b0,
              4'h0, 4'h0, 4'h0, pack_states(run, rdy, rdy, rdy), 1'b1, 2'd0, 4'h0, 4'h0, 4'h0);
   endtask

   task automatic drive_row(input row_t r);
      rst_l     = r.rst;
      imiss_set = r.ims;
      imiss_clr = r.imc;
      stb_set   = r.sts;
      stb_clr   = r.stc;
      flush     = r.fl;
      ll_issue  = r.lli;
      ll_unit   = ll_unit_pkg::ll_unit_e'(r.llu);
      ll_tid    = r.llt;
      ll_done   = r.lld;
      fetch_ue  = r.ue;
   endtask

   task automatic check_row(input row_t r);
      check_value("wm_imiss", 32'(wm_imiss), 32'(r.e_im));
      check_value("wm_other", 32'(wm_other), 32'(r.e_ot));
      check_value("wm_stbwait", 32'(wm_stbwait), 32'(r.e_st));
      check_value("thr_state", 32'(thr_state), 32'(r.e_state));
      check_value("issue_valid", 32'(issue_valid), 32'(r.e_iv));
      check_value("issue_tid", 32'(issue_tid), 32'(r.e_tid));
      check_value("chk_err_wait", 32'(chk_err_wait), 32'(r.e_ew));
      check_value("chk_err_run", 32'(chk_err_run), 32'(r.e_er));
      check_value("chk_err_sync", 32'(chk_err_sync), 32'(r.e_es));
   endtask

   task automatic clear_inputs;
      imiss_set = '0;
      imiss_clr = '0;
      stb_set   = '0;
      stb_clr   = '0;
      flush     = '0;
      ll_issue  = 1'b0;
      ll_unit   = ll_unit_pkg::LL_MUL;
      ll_tid    = '0;
      ll_done   = '0;
      fetch_ue  = 1'b0;
   endtask

   task automatic wait_for_issue(input logic [`TID_W-1:0] tid);
      int n;
      n = 0;
      while (!(issue_valid && issue_tid == tid))
      begin
         if (n == issue_limit)
            stop_on_failure($sformatf("Timeout: thread %0d was never issued", tid));
         @(negedge clk);
         n++;
      end
   endtask

   // A random thread waits on the store buffer, wakes up and must issue again
   task automatic run_random_rounds;
      integer            rnd;
      logic [`TID_W-1:0] tid;
      for (int k = 0; k < 4; k++)
      begin
         row_idx = rows.size() + k;
         rnd = $random(seed);
         tid = rnd[`TID_W-1:0];
         stb_set[tid] = 1'b1;
         @(negedge clk);
         check_value("wm_stbwait", 32'(wm_stbwait), 32'(1) << tid);
         check_value("thr_state[tid]", 32'(thr_state[tid]), 32'(wt));
         stb_set      = '0;
         stb_clr[tid] = 1'b1;
         @(negedge clk);
         check_value("wm_stbwait", 32'(wm_stbwait), 32'(0));
         check_value("thr_state[tid]", 32'(thr_state[tid]), 32'(rdy));
         clear_inputs();
         wait_for_issue(tid);
         check_value("chk_err_wait", 32'(chk_err_wait), 32'(0));
         check_value("chk_err_run", 32'(chk_err_run), 32'(0));
         check_value("chk_err_sync", 32'(chk_err_sync), 32'(0));
      end
   endtask

   initial
   begin
      seed    = 32'hb53d22b5;
      row_idx = 0;
      rst_l   = 1'b1;
      clear_inputs();
      build_table();
      // The first table row is the last of the 16 reset cycles
      repeat (15) @(negedge clk);
      for (int i = 0; i < rows.size(); i++)
      begin
         row_idx = i;
         drive_row(rows[i]);
         @(negedge clk);
         check_row(rows[i]);
      end
      clear_inputs();
      run_random_rounds();
      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

/* thr_ctl_properties.sv */
// Assertions bound into the thread control top level
//   No X on masks, states and issue outputs after reset
//   WAIT only with a mask set or a flush in the previous cycle
//   An issued thread is never in WAIT

`timescale 1ns/1ps
`default_nettype none
`include "thr_ctl_cfg.svh"

module thr_ctl_properties (
   input logic                                   clk,
   input logic                                   rst_l,
   input logic [`THR_N-1:0]                      flush,
   input logic [`THR_N-1:0]                      wm_imiss,
   input logic [`THR_N-1:0]                      wm_other,
   input logic [`THR_N-1:0]                      wm_stbwait,
   input thr_state_pkg::thr_state_e [`THR_N-1:0] thr_state,
   input logic                                   issue_valid,
   input logic [`TID_W-1:0]                      issue_tid
);

   a_no_x : assert property (@(posedge clk) disable iff (rst_l)
      !$isunknown({wm_imiss, wm_other, wm_stbwait, thr_state, issue_valid, issue_tid}))
      else $error("unknown value on masks, states or issue outputs");

   for (genvar t = 0; t < `THR_N; t++)
   begin : g_thr
      a_wait_mask : assert property (@(posedge clk) disable iff (rst_l)
         (thr_state[t] == thr_state_pkg::THR_WAIT) |->
            (wm_imiss[t] || wm_other[t] || wm_stbwait[t] || $past(flush[t])))
         else $error("thread %0d in WAIT with no mask and no flush", t);
   end

   a_issue_sched : assert property (@(posedge clk) disable iff (rst_l)
      issue_valid |-> (thr_state[issue_tid] != thr_state_pkg::THR_WAIT))
      else $error("issued thread %0d is in WAIT", issue_tid);

endmodule

bind thr_ctl_top thr_ctl_properties u_props (
   .clk         (clk),
   .rst_l       (rst_l),
   .flush       (flush),
   .wm_imiss    (wm_imiss),
   .wm_other    (wm_other),
   .wm_stbwait  (wm_stbwait),
   .thr_state   (thr_state),
   .issue_valid (issue_valid),
   .issue_tid   (issue_tid)
);

`default_nettype wire

/* thr_ctl_top.sv */
// Thread control top level
//   Wait-mask tracker feeding the per-thread scheduler
//   Issue pipeline for uncorrectable fetch errors
//   State checker watching masks, states and unit ownership

`timescale 1ns/1ps
`default_nettype none
`include "thr_ctl_cfg.svh"

module thr_ctl_top (
   input  logic                                   clk,
   input  logic                                   rst_l,
   input  logic [`THR_N-1:0]                      imiss_set,
   input  logic [`THR_N-1:0]                      imiss_clr,
   input  logic [`THR_N-1:0]                      stb_set,
   input  logic [`THR_N-1:0]                      stb_clr,
   input  logic [`THR_N-1:0]                      flush,
   input  logic                                   ll_issue,
   input  ll_unit_pkg::ll_unit_e                  ll_unit,
   input  logic [`TID_W-1:0]                      ll_tid,
   input  logic [ll_unit_pkg::LL_UNIT_N-1:0]      ll_done,
   input  logic                                   fetch_ue,
   output logic [`THR_N-1:0]                      wm_imiss,
   output logic [`THR_N-1:0]                      wm_other,
   output logic [`THR_N-1:0]                      wm_stbwait,
   output thr_state_pkg::thr_state_e [`THR_N-1:0] thr_state,
   output logic                                   issue_valid,
   output logic [`TID_W-1:0]                      issue_tid,
   output logic [`THR_N-1:0]                      chk_err_wait,
   output logic [`THR_N-1:0]                      chk_err_run,
   output logic [`THR_N-1:0]                      chk_err_sync
);

   logic [`THR_N-1:0] wm_any_nxt;
   logic [`THR_N-1:0] ll_clr_nxt;
   logic [`THR_N-1:0] unit_busy;
   logic [`THR_N-1:0] ue_e;
   logic [`THR_N-1:0] ue_m;
   logic [`THR_N-1:0] ue_w;

   thr_wait_mask u_wait_mask (
      .clk        (clk),
      .rst_l      (rst_l),
      .imiss_set  (imiss_set),
      .imiss_clr  (imiss_clr),
      .stb_set    (stb_set),
      .stb_clr    (stb_clr),
      .flush      (flush),
      .ll_issue   (ll_issue),
      .ll_unit    (ll_unit),
      .ll_tid     (ll_tid),
      .ll_done    (ll_done),
      .wm_imiss   (wm_imiss),
      .wm_other   (wm_other),
      .wm_stbwait (wm_stbwait),
      .wm_any_nxt (wm_any_nxt),
      .ll_clr_nxt (ll_clr_nxt),
      .unit_busy  (unit_busy)
   );

   // Scheduler sees next-cycle masks so state and masks update together
   thr_sched_fsm u_sched_fsm (
      .clk         (clk),
      .rst_l       (rst_l),
      .wm_any_nxt  (wm_any_nxt),
      .ll_clr_nxt  (ll_clr_nxt),
      .thr_state   (thr_state),
      .issue_valid (issue_valid),
      .issue_tid   (issue_tid)
   );

   thr_issue_pipe u_issue_pipe (
      .clk         (clk),
      .rst_l       (rst_l),
      .issue_valid (issue_valid),
      .issue_tid   (issue_tid),
      .fetch_ue    (fetch_ue),
      .ue_e        (ue_e),
      .ue_m        (ue_m),
      .ue_w        (ue_w)
   );

   thr_state_check u_state_check (
      .clk          (clk),
      .rst_l        (rst_l),
      .thr_state    (thr_state),
      .wm_imiss     (wm_imiss),
      .wm_other     (wm_other),
      .wm_stbwait   (wm_stbwait),
      .unit_busy    (unit_busy),
      .ue_e         (ue_e),
      .ue_m         (ue_m),
      .ue_w         (ue_w),
      .chk_err_wait (chk_err_wait),
      .chk_err_run  (chk_err_run),
      .chk_err_sync (chk_err_sync)
   );

endmodule

`default_nettype wire

/* thr_state_check.sv */
// Thread state checker
//   Compares each thread's FSM state with its wait masks
//   Flags long-latency units busy for a thread whose wm_other is clear
//   Sticky per-thread error flags, cleared only by reset

`timescale 1ns/1ps
`default_nettype none
`include "thr_ctl_cfg.svh"

module thr_state_check (
   input  logic                                   clk,
   input  logic                                   rst_l,
   input  thr_state_pkg::thr_state_e [`THR_N-1:0] thr_state,
   input  logic [`THR_N-1:0]                      wm_imiss,
   input  logic [`THR_N-1:0]                      wm_other,
   input  logic [`THR_N-1:0]                      wm_stbwait,
   input  logic [`THR_N-1:0]                      unit_busy,
   input  logic [`THR_N-1:0]                      ue_e,
   input  logic [`THR_N-1:0]                      ue_m,
   input  logic [`THR_N-1:0]                      ue_w,
   output logic [`THR_N-1:0]                      chk_err_wait,
   output logic [`THR_N-1:0]                      chk_err_run,
   output logic [`THR_N-1:0]                      chk_err_sync
);

   logic [`THR_N-1:0] any_mask;
   logic [`THR_N-1:0] ue_fly;
   logic [`THR_N-1:0] in_wait;
   logic [`THR_N-1:0] bad_wait;
   logic [`THR_N-1:0] bad_run;
   logic [`THR_N-1:0] bad_sync;

   assign any_mask = wm_imiss | wm_other | wm_stbwait;

   // A fetch error anywhere in E, M or W may leave masks legally inconsistent
   assign ue_fly = ue_e | ue_m | ue_w;

   always_comb
   begin
      for (int t = 0; t < `THR_N; t++)
         in_wait[t] = (thr_state[t] == thr_state_pkg::THR_WAIT);
   end

   // Every non-WAIT state is schedulable
   assign bad_wait = in_wait & ~any_mask;
   assign bad_run  = ~in_wait & any_mask & ~ue_fly;
   assign bad_sync = unit_busy & ~wm_other & ~ue_fly;

   always_ff @(posedge clk)
   begin
      if (rst_l)
      begin
         chk_err_wait <= '0;
         chk_err_run  <= '0;
         chk_err_sync <= '0;
      end
      else
      begin
         chk_err_wait <= chk_err_wait | bad_wait;
         chk_err_run  <= chk_err_run | bad_run;
         chk_err_sync <= chk_err_sync | bad_sync;
      end
   end

endmodule

`default_nettype wire

/* thr_issue_pipe.sv */
// Issue pipeline
//   Decodes an uncorrectable fetch error on the issued thread to one-hot
//   Carries it through the E, M and W stages

`timescale 1ns/1ps
`default_nettype none
`include "thr_ctl_cfg.svh"

module thr_issue_pipe (
   input  logic                 clk,
   input  logic                 rst_l,
   input  logic                 issue_valid,
   input  logic [`TID_W-1:0]    issue_tid,
   input  logic                 fetch_ue,
   output logic [`THR_N-1:0]    ue_e,
   output logic [`THR_N-1:0]    ue_m,
   output logic [`THR_N-1:0]    ue_w
);

   logic [`THR_N-1:0] ue_d;
   logic [`THR_N-1:0] ue_q [`PIPE_STAGES];

   always_comb
   begin
      ue_d = '0;
      if (issue_valid && fetch_ue)
         ue_d[issue_tid] = 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (rst_l)
      begin
         for (int s = 0; s < `PIPE_STAGES; s++)
            ue_q[s] <= '0;
      end
      else
      begin
         ue_q[0] <= ue_d;
         for (int s = 1; s < `PIPE_STAGES; s++)
            ue_q[s] <= ue_q[s-1];
      end
   end

   assign ue_e = ue_q[0];
   assign ue_m = ue_q[1];
   assign ue_w = ue_q[`PIPE_STAGES-1];

endmodule

`default_nettype wire

/* thr_sched_fsm.sv */
// Thread scheduler
//   One five-state FSM per thread driven by next-cycle wait masks
//   Round-robin selection of one schedulable thread per cycle
//   Registered issue_valid and issue_tid

`timescale 1ns/1ps
`default_nettype none
`include "thr_ctl_cfg.svh"

module thr_sched_fsm (
   input  logic                                   clk,
   input  logic                                   rst_l,
   input  logic [`THR_N-1:0]                      wm_any_nxt,
   input  logic [`THR_N-1:0]                      ll_clr_nxt,
   output thr_state_pkg::thr_state_e [`THR_N-1:0] thr_state,
   output logic                                   issue_valid,
   output logic [`TID_W-1:0]                      issue_tid
);

   thr_state_pkg::thr_state_e [`THR_N-1:0] state_nxt;

   logic [`THR_N-1:0] cand;
   logic              pick_vld;
   logic [`TID_W-1:0] pick_tid;
   logic [`TID_W-1:0] idx;

   // A thread can be picked if it is schedulable now and stays unmasked
   always_comb
   begin
      for (int t = 0; t < `THR_N; t++)
         cand[t] = (thr_state[t] != thr_state_pkg::THR_WAIT) && !wm_any_nxt[t];
   end

   // Search starts right after the last issued thread.
   // The index wraps on its own because THR_N fills the id width
   always_comb
   begin
      pick_vld = 1'b0;
      pick_tid = issue_tid;
      idx      = issue_tid;
      for (int k = 0; k < `THR_N; k++)
      begin
         idx = idx + 1'b1;
         if (!pick_vld && cand[idx])
         begin
            pick_vld = 1'b1;
            pick_tid = idx;
         end
      end
   end

   always_comb
   begin
      for (int t = 0; t < `THR_N; t++)
      begin
         if (wm_any_nxt[t])
         begin
            state_nxt[t] = thr_state_pkg::THR_WAIT;
         end
         else if (thr_state[t] == thr_state_pkg::THR_WAIT)
         begin
            // Woken threads need one cycle in a ready state before issue
            state_nxt[t] = ll_clr_nxt[t] ? thr_state_pkg::THR_SPEC_RDY :
                                           thr_state_pkg::THR_RDY;
         end
         else if (pick_vld && pick_tid == `TID_W'(t))
         begin
            state_nxt[t] = (thr_state[t] == thr_state_pkg::THR_SPEC_RDY) ?
                           thr_state_pkg::THR_SPEC_RUN : thr_state_pkg::THR_RUN;
         end
         else
         begin
            // Losing the arbitration drops speculation as well
            state_nxt[t] = thr_state_pkg::THR_RDY;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst_l)
      begin
         for (int t = 0; t < `THR_N; t++)
            thr_state[t] <= thr_state_pkg::THR_RDY;
         issue_valid <= 1'b0;
         // Points at the last thread so thread 0 goes first
         issue_tid   <= `TID_W'(`THR_N - 1);
      end
      else
      begin
         thr_state   <= state_nxt;
         issue_valid <= pick_vld;
         if (pick_vld)
            issue_tid <= pick_tid;
      end
   end

endmodule

`default_nettype wire

/* thr_wait_mask.sv */
// Wait-mask tracker
//   Per-thread imiss, store-buffer and long-latency wait masks
//   Busy bit and owner id for each long-latency unit
//   Next-cycle mask OR and long-latency wakeup for the scheduler

`timescale 1ns/1ps
`default_nettype none
`include "thr_ctl_cfg.svh"

module thr_wait_mask (
   input  logic                              clk,
   input  logic                              rst_l,
   input  logic [`THR_N-1:0]                 imiss_set,
   input  logic [`THR_N-1:0]                 imiss_clr,
   input  logic [`THR_N-1:0]                 stb_set,
   input  logic [`THR_N-1:0]                 stb_clr,
   input  logic [`THR_N-1:0]                 flush,
   input  logic                              ll_issue,
   input  ll_unit_pkg::ll_unit_e             ll_unit,
   input  logic [`TID_W-1:0]                 ll_tid,
   input  logic [ll_unit_pkg::LL_UNIT_N-1:0] ll_done,
   output logic [`THR_N-1:0]                 wm_imiss,
   output logic [`THR_N-1:0]                 wm_other,
   output logic [`THR_N-1:0]                 wm_stbwait,
   output logic [`THR_N-1:0]                 wm_any_nxt,
   output logic [`THR_N-1:0]                 ll_clr_nxt,
   output logic [`THR_N-1:0]                 unit_busy
);

   localparam int UNITS = ll_unit_pkg::LL_UNIT_N;

   logic [UNITS-1:0]  busy_q;
   logic [`TID_W-1:0] owner_q [UNITS];
   logic [UNITS-1:0]  busy_nxt;
   logic [`TID_W-1:0] owner_nxt [UNITS];
   logic              issue_acc;
   logic [`THR_N-1:0] other_set;
   logic [`THR_N-1:0] other_clr;
   logic [`THR_N-1:0] done_hit;
   logic [`THR_N-1:0] own_nxt;
   logic [`THR_N-1:0] imiss_nxt;
   logic [`THR_N-1:0] stb_nxt;
   logic [`THR_N-1:0] other_nxt;

   // An issue to a unit that is still working is dropped
   assign issue_acc = ll_issue && (int'(ll_unit) < UNITS) && !busy_q[ll_unit];

   always_comb
   begin
      busy_nxt = busy_q;
      for (int u = 0; u < UNITS; u++)
      begin
         owner_nxt[u] = owner_q[u];
         if (ll_done[u])
            busy_nxt[u] = 1'b0;
         if (issue_acc && int'(ll_unit) == u)
         begin
            busy_nxt[u]  = 1'b1;
            owner_nxt[u] = ll_tid;
         end
      end
   end

   // Ownership seen per thread, now and after this edge
   always_comb
   begin
      for (int t = 0; t < `THR_N; t++)
      begin
         unit_busy[t] = 1'b0;
         done_hit[t]  = 1'b0;
         own_nxt[t]   = 1'b0;
         other_set[t] = issue_acc && (ll_tid == `TID_W'(t));
         for (int u = 0; u < UNITS; u++)
         begin
            if (busy_q[u] && owner_q[u] == `TID_W'(t))
            begin
               unit_busy[t] = 1'b1;
               if (ll_done[u])
                  done_hit[t] = 1'b1;
            end
            if (busy_nxt[u] && owner_nxt[u] == `TID_W'(t))
               own_nxt[t] = 1'b1;
         end
      end
   end

   // The long-latency mask drops only when the thread's last unit completes
   assign other_clr = done_hit & ~own_nxt;

   // Flush wins over set, set wins over clear
   assign imiss_nxt = ~flush & (imiss_set | (wm_imiss & ~imiss_clr));
   assign stb_nxt   = ~flush & (stb_set | (wm_stbwait & ~stb_clr));
   assign other_nxt = ~flush & (other_set | (wm_other & ~other_clr));

   assign wm_any_nxt = imiss_nxt | stb_nxt | other_nxt;

   // Thread wakes because of a completion, so it may run speculatively
   assign ll_clr_nxt = other_clr & wm_other & ~flush & ~wm_any_nxt;

   always_ff @(posedge clk)
   begin
      if (rst_l)
      begin
         wm_imiss   <= '0;
         wm_other   <= '0;
         wm_stbwait <= '0;
         busy_q     <= '0;
      end
      else
      begin
         wm_imiss   <= imiss_nxt;
         wm_other   <= other_nxt;
         wm_stbwait <= stb_nxt;
         busy_q     <= busy_nxt;
      end
   end

   // Owner id is only meaningful while the busy bit is set
   always_ff @(posedge clk)
   begin
      for (int u = 0; u < UNITS; u++)
         owner_q[u] <= owner_nxt[u];
   end

endmodule

`default_nettype wire

/* ll_unit_pkg.sv */
// Long-latency unit selection
//   LL_UNIT_N  number of long-latency units
//   ll_unit_e  opcode that picks a unit

`default_nettype none

package ll_unit_pkg;

   // One unit each for multiply, divide and floating point
   localparam int LL_UNIT_N = 3;

   // Encoding also serves as the index into per-unit vectors
   typedef enum logic [1:0] {
      LL_MUL = 2'd0,
      LL_DIV = 2'd1,
      LL_FP  = 2'd2
   } ll_unit_e;

endpackage

`default_nettype wire

/* thr_state_pkg.sv */
// Thread scheduling state encoding
//   thr_state_e  state of one per-thread FSM

`default_nettype none

package thr_state_pkg;

   // WAIT holds the thread off the issue slot until all masks clear.
   // SPEC_RDY and SPEC_RUN mark a thread woken early by a long-latency completion
   typedef enum logic [2:0] {
      THR_WAIT     = 3'd0,
      THR_RDY      = 3'd1,
      THR_SPEC_RDY = 3'd2,
      THR_RUN      = 3'd3,
      THR_SPEC_RUN = 3'd4
   } thr_state_e;

endpackage

`default_nettype wire

/* thr_ctl_cfg.svh */
// Build-time sizes for the thread control block
//   THR_N        number of hardware threads
//   TID_W        width of a thread id
//   PIPE_STAGES  issue pipeline stages after issue (E, M, W)

`ifndef THR_CTL_CFG_SVH
`define THR_CTL_CFG_SVH

// Four threads in the core
`define THR_N 4

// Must satisfy 2**TID_W == THR_N since the round-robin pointer wraps naturally
`define TID_W 2

// E, M and W
`define PIPE_STAGES 3

`endif
